//--- Bender.yml
package:
  name: video_out

sources:
  - design/video_pkg.sv
  - design/pingpong_buffer.sv
  - design/pixel_reader.sv
  - design/raster_scan.sv
  - design/video_out.sv
  - target: test
    files:
      - verif/video_out_assertions.sv
      - verif/video_out_tb.sv

//--- design/pingpong_buffer.sv
module pingpong_buffer #(
  parameter int DEPTH = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_wr_stb,
  input  video_pkg::pixel_word_t i_wr_data,
  input  logic                   i_wr_commit,
  output logic                   o_wr_full,
  output logic                   o_read_rdy,
  input  logic                   i_read_act,
  input  logic                   i_read_stb,
  output video_pkg::block_size_t o_read_size,
  output video_pkg::pixel_word_t o_read_data
);

  import video_pkg::*;

  localparam int ADDR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_W = $clog2(DEPTH + 1);

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [COUNT_W-1:0] count_t;

  pixel_word_t mem [2][DEPTH];

  count_t      fill_count [2];
  logic [1:0]  committed;   // bank handed over and not yet released.
  logic        wr_bank;
  logic        rd_bank;
  addr_t       rd_addr;
  logic        act_q;

  logic        bank_space;
  logic        wr_accept;
  logic        commit_ok;
  logic        release_bank;

  // the write bank must be free and still have room for another word.
  assign bank_space = fill_count[wr_bank] != count_t'(DEPTH);
  assign wr_accept  = i_wr_stb && !o_wr_full && bank_space;

  // an empty bank is never handed over.
  assign commit_ok = i_wr_commit && !committed[wr_bank] &&
                     ((fill_count[wr_bank] != '0) || wr_accept);

  // the reader lets go of a bank by dropping its activity level.
  assign release_bank = act_q && !i_read_act;

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      mem[wr_bank][addr_t'(fill_count[wr_bank])] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      fill_count[0] <= '0;
      fill_count[1] <= '0;
      committed     <= '0;
      wr_bank       <= 1'b0;
      rd_bank       <= 1'b0;
      rd_addr       <= '0;
      act_q         <= 1'b0;
    end else begin
      act_q <= i_read_act;

      if (wr_accept) begin
        fill_count[wr_bank] <= fill_count[wr_bank] + 1'b1;
      end

      if (commit_ok) begin
        committed[wr_bank] <= 1'b1;
        wr_bank            <= ~wr_bank;   // banks alternate so commit order is kept.
      end

      if (release_bank) begin
        committed[rd_bank]  <= 1'b0;
        fill_count[rd_bank] <= '0;
        rd_bank             <= ~rd_bank;
        rd_addr             <= '0;
      end else if (i_read_act && i_read_stb) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // no bank can take writes while the one under the write pointer is still committed.
  assign o_wr_full = committed[wr_bank];

  // a bank that is still being released does not count as waiting.
  assign o_read_rdy = committed[rd_bank] && !i_read_act && !act_q;

  assign o_read_size = block_size_t'(fill_count[rd_bank]);
  assign o_read_data = mem[rd_bank][rd_addr];   // first word falls through.

endmodule

//--- design/pixel_reader.sv
module pixel_reader (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_read_rdy,
  output logic                   o_read_act,
  input  video_pkg::block_size_t i_read_size,
  input  video_pkg::pixel_word_t i_read_data,
  output logic                   o_read_stb,
  output video_pkg::pixel_t      o_pixel,
  output logic                   o_last,
  output logic                   o_pixel_rdy,
  input  logic                   i_pixel_stb,
  input  logic                   i_tp_red,
  input  logic                   i_tp_green,
  input  logic                   i_tp_blue
);

  import video_pkg::*;

  block_size_t read_count;
  block_size_t count_next;
  logic        words_left;
  pixel_t      pixel_next;

  assign words_left = read_count < i_read_size;

  // the scanner only strobes on ready, so each strobe takes one word.
  assign o_read_stb = o_pixel_rdy && i_pixel_stb;
  assign count_next = o_read_stb ? read_count + 1'b1 : read_count;

  // each enabled test pattern drives its channel to full scale.
  always_comb begin
    pixel_next = i_read_data.pixel;
    if (i_tp_red) begin
      pixel_next.red = COLOR_FULL;
    end
    if (i_tp_green) begin
      pixel_next.green = COLOR_FULL;
    end
    if (i_tp_blue) begin
      pixel_next.blue = COLOR_FULL;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_read_act  <= 1'b0;
      o_pixel_rdy <= 1'b0;
      o_last      <= 1'b0;
      read_count  <= '0;
    end else begin
      if (!o_read_act) begin
        o_pixel_rdy <= 1'b0;
        if (i_read_rdy) begin
          o_read_act <= 1'b1;
          read_count <= '0;
        end
      end else begin
        read_count  <= count_next;
        o_pixel_rdy <= count_next < i_read_size;
        if (!words_left) begin
          o_read_act <= 1'b0;   // the whole block has been taken.
        end
      end

      if (o_read_stb) begin
        o_last <= i_read_data.last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (o_read_stb) begin
      o_pixel <= pixel_next;
    end
  end

endmodule

//--- design/raster_scan.sv
module raster_scan #(
  parameter int H_ACTIVE = 640,
  parameter int H_BLANK  = 160,
  parameter int V_ACTIVE = 480,
  parameter int V_BLANK  = 45
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              i_pixel_rdy,
  output logic              o_pixel_stb,
  input  video_pkg::pixel_t i_pixel,
  input  logic              i_last,
  output video_pkg::pixel_t o_rgb,
  output logic              o_de,
  output logic              o_hsync,
  output logic              o_vsync,
  output logic              o_underrun
);

  import video_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_BLANK;
  localparam int V_TOTAL = V_ACTIVE + V_BLANK;
  localparam int COL_W   = (H_TOTAL > 1) ? $clog2(H_TOTAL) : 1;
  localparam int LINE_W  = (V_TOTAL > 1) ? $clog2(V_TOTAL) : 1;

  typedef logic [COL_W-1:0]  col_t;
  typedef logic [LINE_W-1:0] line_t;

  scan_state_t state;
  col_t        col;
  line_t       line;

  logic in_frame;
  logic active;
  logic line_end;
  logic frame_end;
  logic last_seen;
  logic stb_q;
  logic de_q;
  logic hsync_q;
  logic vsync_q;

  assign in_frame  = state != wait_frame;
  assign active    = in_frame && (int'(col) < H_ACTIVE) && (int'(line) < V_ACTIVE);
  assign line_end  = col == col_t'(H_TOTAL - 1);
  assign frame_end = line_end && (line == line_t'(V_TOTAL - 1));

  // the staged word from the previous strobe closes the frame.
  assign last_seen = stb_q && i_last;

  assign o_pixel_stb = (state == active_frame) && active && i_pixel_rdy && !last_seen;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= wait_frame;
      col   <= '0;
      line  <= '0;
    end else begin
      case (state)
        wait_frame: begin
          col  <= '0;
          line <= '0;
          if (i_pixel_rdy) begin
            state <= active_frame;
          end
        end
        active_frame, finish_frame: begin
          if (line_end) begin
            col  <= '0;
            line <= frame_end ? '0 : line + 1'b1;
          end else begin
            col <= col + 1'b1;
          end
          if (frame_end) begin
            if (state == finish_frame || last_seen) begin
              state <= wait_frame;
            end
          end else if (last_seen) begin
            state <= finish_frame;
          end
        end
        default: state <= wait_frame;
      endcase
    end
  end

  // timing is delayed two cycles to line up with the staged pixel.
  always_ff @(posedge clk) begin
    if (rst) begin
      stb_q      <= 1'b0;
      de_q       <= 1'b0;
      hsync_q    <= 1'b0;
      vsync_q    <= 1'b0;
      o_de       <= 1'b0;
      o_hsync    <= 1'b0;
      o_vsync    <= 1'b0;
      o_underrun <= 1'b0;
    end else begin
      stb_q   <= o_pixel_stb;
      de_q    <= active;
      hsync_q <= in_frame && (int'(col) >= H_ACTIVE);
      vsync_q <= in_frame && (int'(line) >= V_ACTIVE);
      o_de    <= de_q;
      o_hsync <= hsync_q;
      o_vsync <= vsync_q;
      if ((state == active_frame) && active && !i_pixel_rdy && !last_seen) begin
        o_underrun <= 1'b1;   // sticky until reset.
      end
    end
  end

  always_ff @(posedge clk) begin
    o_rgb <= stb_q ? i_pixel : PIXEL_BLACK;
  end

endmodule

//--- design/video_out.sv
module video_out #(
  parameter int DEPTH    = 16,
  parameter int H_ACTIVE = 640,
  parameter int H_BLANK  = 160,
  parameter int V_ACTIVE = 480,
  parameter int V_BLANK  = 45
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_wr_stb,
  input  video_pkg::pixel_word_t i_wr_data,
  input  logic                   i_wr_commit,
  input  logic                   i_tp_red,
  input  logic                   i_tp_green,
  input  logic                   i_tp_blue,
  output logic                   o_wr_full,
  output video_pkg::pixel_t      o_rgb,
  output logic                   o_de,
  output logic                   o_hsync,
  output logic                   o_vsync,
  output logic                   o_underrun
);

  import video_pkg::*;

  logic        read_rdy;
  logic        read_act;
  logic        read_stb;
  block_size_t read_size;
  pixel_word_t read_data;

  pixel_t      pixel;
  logic        last;
  logic        pixel_rdy;
  logic        pixel_stb;

  pingpong_buffer #(
    .DEPTH(DEPTH)
  ) u_buffer (
    .clk        (clk),
    .rst        (rst),
    .i_wr_stb   (i_wr_stb),
    .i_wr_data  (i_wr_data),
    .i_wr_commit(i_wr_commit),
    .o_wr_full  (o_wr_full),
    .o_read_rdy (read_rdy),
    .i_read_act (read_act),
    .i_read_stb (read_stb),
    .o_read_size(read_size),
    .o_read_data(read_data)
  );

  pixel_reader u_reader (
    .clk        (clk),
    .rst        (rst),
    .i_read_rdy (read_rdy),
    .o_read_act (read_act),
    .i_read_size(read_size),
    .i_read_data(read_data),
    .o_read_stb (read_stb),
    .o_pixel    (pixel),
    .o_last     (last),
    .o_pixel_rdy(pixel_rdy),
    .i_pixel_stb(pixel_stb),
    .i_tp_red   (i_tp_red),
    .i_tp_green (i_tp_green),
    .i_tp_blue  (i_tp_blue)
  );

  raster_scan #(
    .H_ACTIVE(H_ACTIVE),
    .H_BLANK (H_BLANK),
    .V_ACTIVE(V_ACTIVE),
    .V_BLANK (V_BLANK)
  ) u_scan (
    .clk        (clk),
    .rst        (rst),
    .i_pixel_rdy(pixel_rdy),
    .o_pixel_stb(pixel_stb),
    .i_pixel    (pixel),
    .i_last     (last),
    .o_rgb      (o_rgb),
    .o_de       (o_de),
    .o_hsync    (o_hsync),
    .o_vsync    (o_vsync),
    .o_underrun (o_underrun)
  );

endmodule

//--- design/video_pkg.sv
package video_pkg;

  // one colour channel of a pixel.
  typedef logic [7:0] color_t;

  // number of words held in a committed block.
  typedef logic [23:0] block_size_t;

  typedef struct packed {
    color_t red;
    color_t green;
    color_t blue;
  } pixel_t;

  // bit 24 flags the final pixel of a frame.
  typedef struct packed {
    logic   last;
    pixel_t pixel;
  } pixel_word_t;

  typedef enum logic [1:0] {
    wait_frame,
    active_frame,
    finish_frame
  } scan_state_t;

  // full scale value forced by a test-pattern enable.
  localparam color_t COLOR_FULL = 8'hff;

  // colour driven during blanking and underrun.
  localparam pixel_t PIXEL_BLACK = '0;

endpackage

//--- project.f
design/video_pkg.sv
design/pingpong_buffer.sv
design/pixel_reader.sv
design/raster_scan.sv
design/video_out.sv
verif/video_out_assertions.sv
verif/video_out_tb.sv

//--- verif/video_out_assertions.sv
module video_out_assertions (
  input logic                   clk,
  input logic                   rst,
  input logic                   i_act,
  input logic                   i_stb,
  input video_pkg::block_size_t i_size,
  input logic                   i_rdy,
  input logic                   i_req
);

  timeunit 1ns;
  timeprecision 1ps;

  import video_pkg::*;

  block_size_t stb_count;   // words taken since the block was acquired.

  always_ff @(posedge clk) begin
    if (rst || !i_act) begin
      stb_count <= '0;
    end else if (i_stb) begin
      stb_count <= stb_count + 1'b1;
    end
  end

  stb_needs_act: assert property (@(posedge clk) disable iff (rst) i_stb |-> i_act)
    else $error("read strobe while no block is active");

  req_needs_rdy: assert property (@(posedge clk) disable iff (rst) i_req |-> i_rdy)
    else $error("a request arrived while its ready level was low");

  stb_within_size: assert property (@(posedge clk) disable iff (rst)
    (i_act && i_stb) |-> (stb_count < i_size))
    else $error("more read strobes than words in the block");

endmodule

bind pixel_reader video_out_assertions u_reader_checks (
  .clk(clk), .rst(rst), .i_act(o_read_act), .i_stb(o_read_stb),
  .i_size(i_read_size), .i_rdy(o_pixel_rdy), .i_req(i_pixel_stb)
);

// the reader may only hold a block while the bank under the read pointer is committed.
bind pingpong_buffer video_out_assertions u_buffer_checks (
  .clk(clk), .rst(rst), .i_act(i_read_act), .i_stb(i_read_stb),
  .i_size(o_read_size), .i_rdy(committed[rd_bank]), .i_req(i_read_act)
);

//--- verif/video_out_tb.sv
module video_out_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import video_pkg::*;

  localparam int DEPTH       = 16;
  localparam int H_ACTIVE    = 8;
  localparam int H_BLANK     = 4;
  localparam int V_ACTIVE    = 4;
  localparam int V_BLANK     = 2;
  localparam int H_TOTAL     = H_ACTIVE + H_BLANK;
  localparam int V_TOTAL     = V_ACTIVE + V_BLANK;
  localparam int FRAME_WORDS = H_ACTIVE * V_ACTIVE;
  localparam int FRAMES      = 9;   // frames shown by all tests together.
  localparam int LOAD_CYCLES = FRAMES * 2 * (DEPTH + 4);
  localparam int TIMEOUT     = 2 * (FRAMES * H_TOTAL * V_TOTAL + LOAD_CYCLES);

  logic        clk;
  logic        rst;
  logic        i_wr_stb;
  pixel_word_t i_wr_data;
  logic        i_wr_commit;
  logic        i_tp_red;
  logic        i_tp_green;
  logic        i_tp_blue;
  logic        o_wr_full;
  pixel_t      o_rgb;
  logic        o_de;
  logic        o_hsync;
  logic        o_vsync;
  logic        o_underrun;

  pixel_word_t wr_q[$];
  pixel_t      exp_q[$];   // pixels the display must show, in order.
  pixel_t      exp_pixel;
  int          pixel_errs = 0;
  int          sync_errs = 0;
  int          ctrl_errs = 0;
  int          frames_done = 0;
  int          cycle_count;
  int          line_de;
  int          hsync_rises;
  int          vsync_lines;
  int          de_lines;
  int          frame_hsync_rises;
  int          frame_vsync_lines;
  int          frame_de_lines;
  logic        hsync_prev;
  logic        vsync_prev;
  logic        underrun_seen;

  video_out #(
    .DEPTH   (DEPTH),
    .H_ACTIVE(H_ACTIVE),
    .H_BLANK (H_BLANK),
    .V_ACTIVE(V_ACTIVE),
    .V_BLANK (V_BLANK)
  ) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT) begin
      @(posedge clk);
      cycle_count++;
    end
    ctrl_errs++;
    $display("timeout: the tests did not complete within %0d cycles", TIMEOUT);
    finish_run();
  end

  // outputs move on the rising edge, so the falling edge sees them settled.
  always @(negedge clk) begin
    if (rst) begin
      line_de       = 0;
      hsync_rises   = 0;
      vsync_lines   = 0;
      de_lines      = 0;
      hsync_prev    = 1'b0;
      vsync_prev    = 1'b0;
      underrun_seen = 1'b0;
    end else begin
      if (o_de) begin
        assert (exp_q.size() != 0) else begin
          pixel_errs++;
          $display("active pixel %h shown with no written pixel left", o_rgb);
        end
        if (exp_q.size() != 0) begin
          exp_pixel = exp_q.pop_front();
          assert (o_rgb == exp_pixel) else begin
            pixel_errs++;
            $display("FAIL o_rgb: got %h, expected %h", o_rgb, exp_pixel);
          end
        end
        line_de++;
      end
      if (o_hsync && !hsync_prev) begin
        assert (line_de == (o_vsync ? 0 : H_ACTIVE)) else begin
          sync_errs++;
          $display("FAIL o_de per line: got %h, expected %h", line_de, o_vsync ? 0 : H_ACTIVE);
        end
        hsync_rises++;
        if (o_vsync)
          vsync_lines++;
        else if (line_de == H_ACTIVE)
          de_lines++;
        line_de = 0;
      end
      if (!o_vsync && vsync_prev) begin   // the end of vertical blanking closes a frame.
        frame_hsync_rises = hsync_rises;
        frame_vsync_lines = vsync_lines;
        frame_de_lines    = de_lines;
        hsync_rises       = 0;
        vsync_lines       = 0;
        de_lines          = 0;
        frames_done++;
      end
      assert (!underrun_seen || o_underrun) else begin
        ctrl_errs++;
        $display("o_underrun went low again without a reset");
      end
      underrun_seen = underrun_seen || o_underrun;
      hsync_prev    = o_hsync;
      vsync_prev    = o_vsync;
    end
  end

  task automatic finish_run();
    $display("pixel errors %0d, sync errors %0d, control errors %0d",
             pixel_errs, sync_errs, ctrl_errs);
    if (pixel_errs + sync_errs + ctrl_errs == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  // an enabled test pattern puts its channel at full scale.
  function automatic pixel_t with_test_pattern(input pixel_t p);
    pixel_t q;
    q = p;
    if (i_tp_red)
      q.red = 8'hff;
    if (i_tp_green)
      q.green = 8'hff;
    if (i_tp_blue)
      q.blue = 8'hff;
    return q;
  endfunction

  task automatic queue_words(input int n, input bit mark_last);
    pixel_word_t w;
    for (int i = 0; i < n; i++) begin
      w.pixel = 24'($urandom);
      w.last  = mark_last && (i == n - 1);
      wr_q.push_back(w);
      exp_q.push_back(with_test_pattern(w.pixel));
    end
  endtask

  task automatic write_block(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      i_wr_stb = 1'b0;
      while (o_wr_full) @(negedge clk);   // hold off until a bank is free.
      i_wr_stb  = 1'b1;
      i_wr_data = wr_q.pop_front();
    end
    @(negedge clk);
    i_wr_stb    = 1'b0;
    i_wr_commit = 1'b1;
    @(negedge clk);
    i_wr_commit = 1'b0;
  endtask

  task automatic load_frame();
    queue_words(FRAME_WORDS, 1'b1);
    write_block(DEPTH);
    write_block(DEPTH);
  endtask

  task automatic wait_frames(input int n);
    int target;
    target = frames_done + n;
    while (frames_done < target) @(negedge clk);
  endtask

  task automatic check_frame();
    assert (exp_q.size() == 0) else begin
      pixel_errs++;
      $display("%0d written pixels never reached the display", exp_q.size());
    end
    exp_q.delete();
    assert (!o_underrun) else begin
      ctrl_errs++;
      $display("FAIL o_underrun: got %h, expected %h", o_underrun, 1'b0);
    end
  endtask

  task automatic check_sync();
    assert (frame_hsync_rises == V_TOTAL) else begin
      sync_errs++;
      $display("FAIL o_hsync rises: got %h, expected %h", frame_hsync_rises, V_TOTAL);
    end
    assert (frame_vsync_lines == V_BLANK) else begin
      sync_errs++;
      $display("FAIL o_vsync lines: got %h, expected %h", frame_vsync_lines, V_BLANK);
    end
    assert (frame_de_lines == V_ACTIVE) else begin
      sync_errs++;
      $display("FAIL o_de lines: got %h, expected %h", frame_de_lines, V_ACTIVE);
    end
  endtask

  task automatic test_frame_order();
    load_frame();
    wait_frames(1);
    check_frame();
  endtask

  task automatic test_sync_timing();
    load_frame();
    wait_frames(1);
    check_frame();
    check_sync();
  endtask

  task automatic test_pattern(input logic red, input logic green, input logic blue);
    i_tp_red   = red;
    i_tp_green = green;
    i_tp_blue  = blue;
    load_frame();
    wait_frames(1);
    check_frame();
    i_tp_red   = 1'b0;
    i_tp_green = 1'b0;
    i_tp_blue  = 1'b0;
  endtask

  task automatic test_back_pressure();
    pixel_word_t extra;
    load_frame();
    // both banks now hold committed words and the first one is still being read.
    for (int i = 0; i < 3; i++) begin
      assert (o_wr_full) else begin
        ctrl_errs++;
        $display("FAIL o_wr_full: got %h, expected %h", o_wr_full, 1'b1);
      end
      extra.pixel = 24'($urandom);
      extra.last  = 1'b0;
      i_wr_stb    = 1'b1;
      i_wr_data   = extra;
      @(negedge clk);
    end
    i_wr_stb = 1'b0;
    wait_frames(1);
    check_frame();
  endtask

  task automatic test_underrun();
    queue_words(DEPTH, 1'b0);
    repeat (FRAME_WORDS - DEPTH) exp_q.push_back('0);   // starved pixels show black.
    write_block(DEPTH);
    while (exp_q.size() != 0) @(negedge clk);
    assert (o_underrun) else begin
      ctrl_errs++;
      $display("FAIL o_underrun: got %h, expected %h", o_underrun, 1'b1);
    end
    apply_reset();
  endtask

  task automatic test_two_frames();
    load_frame();
    wait_frames(1);
    check_frame();
    check_sync();
    repeat (H_TOTAL) begin
      @(negedge clk);
      assert (!o_de && !o_hsync && !o_vsync) else begin
        sync_errs++;
        $display("the scanner left its idle state with no new data");
      end
    end
    load_frame();
    wait_frames(1);
    check_frame();
    check_sync();
  endtask

  initial begin
    void'($urandom(32'hcfadca44));
    i_wr_stb    = 1'b0;
    i_wr_data   = '0;
    i_wr_commit = 1'b0;
    i_tp_red    = 1'b0;
    i_tp_green  = 1'b0;
    i_tp_blue   = 1'b0;
    apply_reset();
    test_frame_order();
    test_sync_timing();
    test_pattern(1'b0, 1'b1, 1'b0);
    test_pattern(1'b1, 1'b0, 1'b0);
    test_pattern(1'b0, 1'b0, 1'b1);
    test_back_pressure();
    test_underrun();
    test_two_frames();
    finish_run();
  end

endmodule
